// File: hw/stk_pkg.sv
package stk_pkg;

    localparam int DATA_W = 8; // One stack or memory word.
    localparam int ADDR_W = 8; // Data memory address.
    localparam int OPC_W  = 4;

    // Codes not listed here execute as a one-cycle no-op.
    typedef enum logic [OPC_W-1:0] {
        OP_PUSHC = 4'd0,
        OP_PUSHM = 4'd1,
        OP_POPM  = 4'd2,
        OP_ADD   = 4'd4,
        OP_SUB   = 4'd5, // Second minus top.
        OP_AND   = 4'd6,
        OP_OR    = 4'd7,
        OP_JMP   = 4'd8,
        OP_JZ    = 4'd9, // Tests top without popping.
        OP_HALT  = 4'd15
    } opcode_t;

    // The operand is an address or a constant depending on the opcode.
    typedef struct packed {
        opcode_t             opc;
        logic [DATA_W-1:0]   operand;
    } instr_t;

    typedef struct packed {
        logic                push;
        logic                pop;
        logic [DATA_W-1:0]   data;
    } stk_req_t;

    typedef struct packed {
        logic                rd_en;
        logic                wr_en;
        logic [ADDR_W-1:0]   addr;
        logic [DATA_W-1:0]   wdata;
    } mem_req_t;

endpackage

// File: hw/push_pop_unit.sv
`timescale 1ns/1ps

module push_pop_unit (
    input  logic                         clk,
    input  logic                         rstn,
    input  logic                         en,
    input  stk_pkg::opcode_t             opc,
    input  logic [stk_pkg::DATA_W-1:0]   operand,
    input  logic [stk_pkg::DATA_W-1:0]   stk_top,
    input  logic [stk_pkg::DATA_W-1:0]   mem_rd_data,
    output stk_pkg::stk_req_t            stk_req,
    output stk_pkg::mem_req_t            mem_req,
    output logic                         fin
);
    import stk_pkg::*;

    typedef enum logic [2:0] {
        PP_IDLE   = 3'b000,
        PP_LOAD   = 3'b001,
        PP_PUSH   = 3'b010,
        PP_PUSH_D = 3'b011,
        PP_POP    = 3'b100,
        PP_POP_D  = 3'b101,
        PP_STORE  = 3'b110
    } pp_state_t;

    pp_state_t           state;
    opcode_t             opc_q;
    logic [DATA_W-1:0]   arg_q;   // Constant for PUSHC, address for POPM.

    // Outputs are registered and take effect in the state being entered.
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state   <= PP_IDLE;
            opc_q   <= OP_PUSHC;
            arg_q   <= '0;
            stk_req <= '0;
            mem_req <= '0;
            fin     <= 1'b0;
        end else begin
            // Requests last one cycle unless set again below.
            stk_req       <= '0;
            mem_req.rd_en <= 1'b0;
            mem_req.wr_en <= 1'b0;
            fin           <= 1'b0;

            case (state)
                PP_IDLE: begin
                    if (en) begin
                        opc_q <= opc;
                        arg_q <= operand;
                        case (opc)
                            OP_PUSHC: state <= PP_PUSH;
                            OP_PUSHM: begin
                                mem_req.rd_en <= 1'b1;
                                mem_req.addr  <= operand;
                                state         <= PP_LOAD;
                            end
                            OP_POPM: begin
                                // Grab the top before the pop moves the pointer.
                                mem_req.wdata <= stk_top;
                                stk_req.pop   <= 1'b1;
                                state         <= PP_POP;
                            end
                            default: state <= PP_IDLE;
                        endcase
                    end
                end
                PP_LOAD: state <= PP_PUSH; // RAM latches the read here.
                PP_PUSH: begin
                    stk_req.data <= (opc_q == OP_PUSHM) ? mem_rd_data : arg_q;
                    stk_req.push <= 1'b1;
                    fin          <= 1'b1;
                    state        <= PP_PUSH_D;
                end
                PP_PUSH_D: state <= PP_IDLE;
                PP_POP: state <= PP_POP_D;
                PP_POP_D: begin
                    mem_req.wr_en <= 1'b1;
                    mem_req.addr  <= arg_q;
                    fin           <= 1'b1;
                    state         <= PP_STORE;
                end
                PP_STORE: state <= PP_IDLE;
                default: state <= PP_IDLE;
            endcase
        end
    end

endmodule

// File: hw/stack_alu_unit.sv
`timescale 1ns/1ps

module stack_alu_unit (
    input  logic                         clk,
    input  logic                         rstn,
    input  logic                         en,
    input  stk_pkg::opcode_t             opc,
    input  logic [stk_pkg::DATA_W-1:0]   stk_top,
    input  logic [stk_pkg::DATA_W-1:0]   stk_second,
    output stk_pkg::stk_req_t            stk_req,
    output logic                         fin
);
    import stk_pkg::*;

    typedef enum logic [1:0] {A_IDLE, A_POP1, A_POP2, A_PUSH} alu_state_t;

    alu_state_t          state;
    opcode_t             op_q;
    logic [DATA_W-1:0]   lhs_q;   // Second from top.
    logic [DATA_W-1:0]   rhs_q;   // Top.
    logic [DATA_W-1:0]   result;

    always_comb begin
        case (op_q)
            OP_ADD:  result = lhs_q + rhs_q; // Wraps at the word width.
            OP_SUB:  result = lhs_q - rhs_q;
            OP_AND:  result = lhs_q & rhs_q;
            OP_OR:   result = lhs_q | rhs_q;
            default: result = '0;
        endcase
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state   <= A_IDLE;
            op_q    <= OP_ADD;
            lhs_q   <= '0;
            rhs_q   <= '0;
            stk_req <= '0;
            fin     <= 1'b0;
        end else begin
            stk_req <= '0;
            fin     <= 1'b0;
            case (state)
                A_IDLE: begin
                    if (en) begin
                        op_q        <= opc;
                        lhs_q       <= stk_second;
                        rhs_q       <= stk_top;
                        stk_req.pop <= 1'b1;
                        state       <= A_POP1;
                    end
                end
                A_POP1: begin
                    stk_req.pop <= 1'b1;
                    state       <= A_POP2;
                end
                A_POP2: begin
                    stk_req.data <= result;
                    stk_req.push <= 1'b1;
                    fin          <= 1'b1;
                    state        <= A_PUSH;
                end
                default: state <= A_IDLE; // A_PUSH returns to idle.
            endcase
        end
    end

endmodule

// File: hw/lifo_stack.sv
`timescale 1ns/1ps

module lifo_stack #(
    parameter int STACK_DEPTH = 8
) (
    input  logic                                 clk,
    input  logic                                 rstn,
    input  stk_pkg::stk_req_t                    req,
    output logic [stk_pkg::DATA_W-1:0]           top,
    output logic [stk_pkg::DATA_W-1:0]           second,
    output logic [$clog2(STACK_DEPTH+1)-1:0]     depth,
    output logic                                 error
);
    import stk_pkg::*;

    localparam int IDX_W = $clog2(STACK_DEPTH);
    localparam int CNT_W = $clog2(STACK_DEPTH + 1);

    logic [DATA_W-1:0]   mem [STACK_DEPTH];
    logic [CNT_W-1:0]    sp;      // Number of valid entries.
    logic [CNT_W-1:0]    sp_m1;
    logic [CNT_W-1:0]    sp_m2;
    logic                full;
    logic                empty;

    assign full  = (sp == CNT_W'(STACK_DEPTH));
    assign empty = (sp == '0);
    assign sp_m1 = sp - 1'b1;
    assign sp_m2 = sp - 2'd2;

    // Missing entries read as zero.
    assign top    = empty ? '0 : mem[sp_m1[IDX_W-1:0]];
    assign second = (sp > CNT_W'(1)) ? mem[sp_m2[IDX_W-1:0]] : '0;
    assign depth  = sp;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            sp    <= '0;
            error <= 1'b0;
        end else if (req.push) begin
            if (full)
                error <= 1'b1; // Overflow, push dropped.
            else
                sp <= sp + 1'b1;
        end else if (req.pop) begin
            if (empty)
                error <= 1'b1; // Underflow.
            else
                sp <= sp_m1;
        end
    end

    always_ff @(posedge clk) begin
        if (req.push && !full)
            mem[sp[IDX_W-1:0]] <= req.data;
    end

endmodule

// File: hw/data_ram.sv
`timescale 1ns/1ps

module data_ram #(
    parameter int MEM_DEPTH = 256
) (
    input  logic                         clk,
    input  stk_pkg::mem_req_t            core_req,
    input  stk_pkg::mem_req_t            host_req,
    input  logic                         host_sel,
    output logic [stk_pkg::DATA_W-1:0]   rd_data
);
    import stk_pkg::*;

    logic [DATA_W-1:0]   mem [MEM_DEPTH];
    mem_req_t            req;

    // One port, owned by the host while the core is idle.
    assign req = host_sel ? host_req : core_req;

    always_ff @(posedge clk) begin
        if (req.wr_en)
            mem[req.addr] <= req.wdata;
        if (req.rd_en)
            rd_data <= mem[req.addr]; // Valid the cycle after rd_en.
    end

endmodule

// File: hw/program_sequencer.sv
`timescale 1ns/1ps

module program_sequencer #(
    parameter int PROG_DEPTH = 64
) (
    input  logic                             clk,
    input  logic                             rstn,
    input  logic                             prog_we,
    input  logic [$clog2(PROG_DEPTH)-1:0]    prog_addr,
    input  stk_pkg::instr_t                  prog_data,
    input  logic                             start,
    input  logic [stk_pkg::DATA_W-1:0]       stk_top,
    input  logic                             stk_error,
    output logic                             pp_en,
    output logic                             alu_en,
    output stk_pkg::opcode_t                 opc,
    output logic [stk_pkg::DATA_W-1:0]       operand,
    input  stk_pkg::stk_req_t                pp_stk_req,
    input  stk_pkg::stk_req_t                alu_stk_req,
    output stk_pkg::stk_req_t                stk_req,
    input  logic                             pp_fin,
    input  logic                             alu_fin,
    output logic                             busy,
    output logic                             halted
);
    import stk_pkg::*;

    localparam int PC_W = $clog2(PROG_DEPTH);

    typedef enum logic [1:0] {SQ_IDLE, SQ_DECODE, SQ_WAIT} sq_state_t;

    instr_t              prog_mem [PROG_DEPTH];
    sq_state_t           state;
    logic [PC_W-1:0]     pc;
    logic [PC_W-1:0]     pc_inc;
    instr_t              instr;
    logic                is_pp;
    logic                is_alu;
    logic                alu_sel;   // Unit that owns the stack port.

    always_ff @(posedge clk) begin
        if (prog_we && !busy)
            prog_mem[prog_addr] <= prog_data;
    end

    // Fetch is combinational and only visible during decode.
    assign instr   = (state == SQ_DECODE) ? prog_mem[pc] : '0;
    assign opc     = instr.opc;
    assign operand = instr.operand;

    assign is_pp  = opc inside {OP_PUSHC, OP_PUSHM, OP_POPM};
    assign is_alu = opc inside {OP_ADD, OP_SUB, OP_AND, OP_OR};
    assign pp_en  = (state == SQ_DECODE) && !stk_error && is_pp;
    assign alu_en = (state == SQ_DECODE) && !stk_error && is_alu;

    assign pc_inc  = (pc == PC_W'(PROG_DEPTH - 1)) ? '0 : pc + 1'b1;
    assign stk_req = alu_sel ? alu_stk_req : pp_stk_req;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state   <= SQ_IDLE;
            pc      <= '0;
            busy    <= 1'b0;
            halted  <= 1'b0;
            alu_sel <= 1'b0;
        end else begin
            case (state)
                SQ_IDLE: begin
                    if (start) begin
                        pc     <= '0;
                        halted <= 1'b0;
                        busy   <= 1'b1;
                        state  <= SQ_DECODE;
                    end
                end
                SQ_DECODE: begin
                    if (stk_error) begin
                        busy   <= 1'b0;
                        halted <= 1'b1;
                        state  <= SQ_IDLE;
                    end else if (is_pp || is_alu) begin
                        alu_sel <= is_alu;
                        state   <= SQ_WAIT;
                    end else begin
                        case (opc)
                            OP_JMP: pc <= operand[PC_W-1:0];
                            OP_JZ:  pc <= (stk_top == '0) ? operand[PC_W-1:0] : pc_inc;
                            OP_HALT: begin
                                busy   <= 1'b0;
                                halted <= 1'b1;
                                state  <= SQ_IDLE;
                            end
                            default: pc <= pc_inc;
                        endcase
                    end
                end
                SQ_WAIT: begin
                    if (pp_fin || alu_fin) begin
                        pc <= pc_inc;
                        // An error seen here stops before the next fetch.
                        if (stk_error) begin
                            busy   <= 1'b0;
                            halted <= 1'b1;
                            state  <= SQ_IDLE;
                        end else begin
                            state <= SQ_DECODE;
                        end
                    end
                end
                default: state <= SQ_IDLE;
            endcase
        end
    end

endmodule

// File: hw/stack_cpu_top.sv
`timescale 1ns/1ps

module stack_cpu_top #(
    parameter int STACK_DEPTH = 8,
    parameter int PROG_DEPTH  = 64,
    parameter int MEM_DEPTH   = 256
) (
    input  logic                             clk,
    input  logic                             rstn,
    input  logic                             prog_we,
    input  logic [$clog2(PROG_DEPTH)-1:0]    prog_addr,
    input  stk_pkg::instr_t                  prog_data,
    input  stk_pkg::mem_req_t                host_req,
    output logic [stk_pkg::DATA_W-1:0]       host_rd_data,
    input  logic                             start,
    output logic                             busy,
    output logic                             halted,
    output logic                             stack_error
);
    import stk_pkg::*;

    logic                                pp_en;
    logic                                alu_en;
    logic                                pp_fin;
    logic                                alu_fin;
    opcode_t                             opc;
    logic [DATA_W-1:0]                   operand;
    logic [DATA_W-1:0]                   stk_top;
    logic [DATA_W-1:0]                   stk_second;
    stk_req_t                            pp_stk_req;
    stk_req_t                            alu_stk_req;
    stk_req_t                            stk_req;
    mem_req_t                            core_mem_req;

    program_sequencer #(.PROG_DEPTH(PROG_DEPTH)) program_sequencer_inst (
        .clk(clk), .rstn(rstn),
        .prog_we(prog_we), .prog_addr(prog_addr), .prog_data(prog_data),
        .start(start), .stk_top(stk_top), .stk_error(stack_error),
        .pp_en(pp_en), .alu_en(alu_en), .opc(opc), .operand(operand),
        .pp_stk_req(pp_stk_req), .alu_stk_req(alu_stk_req), .stk_req(stk_req),
        .pp_fin(pp_fin), .alu_fin(alu_fin), .busy(busy), .halted(halted)
    );

    push_pop_unit push_pop_unit_inst (
        .clk(clk), .rstn(rstn), .en(pp_en), .opc(opc), .operand(operand),
        .stk_top(stk_top), .mem_rd_data(host_rd_data),
        .stk_req(pp_stk_req), .mem_req(core_mem_req), .fin(pp_fin)
    );

    stack_alu_unit stack_alu_unit_inst (
        .clk(clk), .rstn(rstn), .en(alu_en), .opc(opc),
        .stk_top(stk_top), .stk_second(stk_second),
        .stk_req(alu_stk_req), .fin(alu_fin)
    );

    lifo_stack #(.STACK_DEPTH(STACK_DEPTH)) lifo_stack_inst (
        .clk(clk), .rstn(rstn), .req(stk_req),
        .top(stk_top), .second(stk_second), .depth(), .error(stack_error)
    );

    // Host owns the memory whenever the core is not running.
    data_ram #(.MEM_DEPTH(MEM_DEPTH)) data_ram_inst (
        .clk(clk), .core_req(core_mem_req), .host_req(host_req),
        .host_sel(!busy), .rd_data(host_rd_data)
    );

endmodule

// File: verification/stack_cpu_assertions.sv
`timescale 1ns/1ps

module stack_cpu_assertions (
    input logic clk,
    input logic rstn,
    input logic pp_en,
    input logic alu_en,
    input logic pp_fin,
    input logic alu_fin,
    input logic busy
);

    // Only one unit may own an instruction.
    one_unit_at_a_time: assert property (@(posedge clk) disable iff (!rstn)
        !(pp_en && alu_en))
        else $error("pp_en and alu_en high in the same cycle");

    pp_fin_follows_en: assert property (@(posedge clk) disable iff (!rstn)
        pp_en |-> ##[1:3] pp_fin)
        else $error("push_pop_unit did not finish within 3 cycles");

    alu_fin_follows_en: assert property (@(posedge clk) disable iff (!rstn)
        alu_en |-> ##[1:3] alu_fin)
        else $error("stack_alu_unit did not finish within 3 cycles");

    busy_low_in_reset: assert property (@(posedge clk) !rstn |-> !busy)
        else $error("busy high while reset is asserted");

endmodule

bind program_sequencer stack_cpu_assertions stack_cpu_assertions_inst (.*);

// File: verification/stack_cpu_checker.sv
`timescale 1ns/1ps

module stack_cpu_checker #(
    parameter int STACK_DEPTH = 8,
    parameter int PROG_DEPTH  = 64
) (
    input  logic                             clk,
    input  logic                             rstn,
    input  logic                             prog_we,
    input  logic [$clog2(PROG_DEPTH)-1:0]    prog_addr,
    input  stk_pkg::instr_t                  prog_data,
    input  stk_pkg::mem_req_t                host_req,
    input  logic [stk_pkg::DATA_W-1:0]       host_rd_data,
    input  logic                             start,
    input  logic                             busy,
    input  logic                             halted,
    input  logic                             stack_error,
    output int                               err_count
);
    import stk_pkg::*;

    instr_t         prog_img [PROG_DEPTH];
    logic [7:0]     mem_img [256];
    logic [7:0]     stk [STACK_DEPTH];
    int             sp;
    logic           model_err;
    logic           rd_pend;
    logic [7:0]     rd_addr;
    logic           halted_q;
    logic           rstn_q;

    function automatic void push_word(input logic [7:0] v);
        if (sp == STACK_DEPTH) begin
            model_err = 1'b1; // Overflow drops the word.
        end else begin
            stk[sp] = v;
            sp = sp + 1;
        end
    endfunction

    function automatic void pop_word();
        if (sp == 0)
            model_err = 1'b1;
        else
            sp = sp - 1;
    endfunction

    // Instruction-level model of one program run from address 0.
    function automatic void run_model();
        int          pc;
        int          steps;
        instr_t      ins;
        logic [7:0]  a;
        logic [7:0]  b;
        logic        done;
        pc = 0;
        steps = 0;
        done = 1'b0;
        sp = 0;
        model_err = 1'b0;
        while (!done && steps < 2000) begin
            ins = prog_img[pc];
            steps++;
            b = (sp > 0) ? stk[sp-1] : 8'h00; // Empty slots read as zero.
            a = (sp > 1) ? stk[sp-2] : 8'h00;
            case (ins.opc)
                OP_PUSHC: push_word(ins.operand);
                OP_PUSHM: push_word(mem_img[ins.operand]);
                OP_POPM: begin
                    pop_word();
                    mem_img[ins.operand] = b;
                end
                OP_ADD, OP_SUB, OP_AND, OP_OR: begin
                    pop_word();
                    pop_word();
                    case (ins.opc)
                        OP_ADD:  push_word(a + b);
                        OP_SUB:  push_word(a - b);
                        OP_AND:  push_word(a & b);
                        default: push_word(a | b);
                    endcase
                end
                OP_HALT: done = 1'b1;
                default: ;
            endcase
            if (ins.opc == OP_JMP)
                pc = ins.operand % PROG_DEPTH;
            else if (ins.opc == OP_JZ && b == 8'h00)
                pc = ins.operand % PROG_DEPTH;
            else
                pc = (pc + 1) % PROG_DEPTH;
            if (model_err)
                done = 1'b1; // Error halts after the current instruction.
        end
    endfunction

    always @(posedge clk) begin
        rstn_q   <= rstn;
        halted_q <= halted;
        if (rstn && !rstn_q && (busy || halted || stack_error)) begin
            $display("ERR idle after reset busy=%h halted=%h stack_error=%h",
                     busy, halted, stack_error);
            err_count++;
        end
        if (prog_we && !busy)
            prog_img[prog_addr] = prog_data;
        if (host_req.wr_en && !busy)
            mem_img[host_req.addr] = host_req.wdata;
        if (rstn && start && !busy)
            run_model();
        if (halted && !halted_q && stack_error !== model_err) begin
            $display("ERR stack_error exp=%h got=%h", model_err, stack_error);
            err_count++;
        end
        if (rd_pend && host_rd_data !== mem_img[rd_addr]) begin
            $display("ERR host_rd_data addr=%h exp=%h got=%h",
                     rd_addr, mem_img[rd_addr], host_rd_data);
            err_count++;
        end
        rd_pend = host_req.rd_en && !busy;
        rd_addr = host_req.addr;
    end

    initial begin
        err_count = 0;
        rd_pend   = 1'b0;
        rd_addr   = '0;
        halted_q  = 1'b0;
        rstn_q    = 1'b0;
    end

endmodule

// File: verification/stack_cpu_tb.sv
`timescale 1ns/1ps

module stack_cpu_tb;
    import stk_pkg::*;

    localparam int STACK_DEPTH = 8;
    localparam int PROG_DEPTH  = 64;

    logic          clk;
    logic          rstn;
    logic          prog_we;
    logic [5:0]    prog_addr;
    instr_t        prog_data;
    mem_req_t      host_req;
    logic [7:0]    host_rd_data;
    logic          start;
    logic          busy;
    logic          halted;
    logic          stack_error;
    int            chk_errors;
    int            timeouts;

    stack_cpu_top #(.STACK_DEPTH(STACK_DEPTH), .PROG_DEPTH(PROG_DEPTH)) stack_cpu_top_inst (
        .clk(clk), .rstn(rstn), .prog_we(prog_we), .prog_addr(prog_addr),
        .prog_data(prog_data), .host_req(host_req), .host_rd_data(host_rd_data),
        .start(start), .busy(busy), .halted(halted), .stack_error(stack_error)
    );

    stack_cpu_checker #(.STACK_DEPTH(STACK_DEPTH), .PROG_DEPTH(PROG_DEPTH)) checker_inst (
        .clk(clk), .rstn(rstn), .prog_we(prog_we), .prog_addr(prog_addr),
        .prog_data(prog_data), .host_req(host_req), .host_rd_data(host_rd_data),
        .start(start), .busy(busy), .halted(halted), .stack_error(stack_error),
        .err_count(chk_errors)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic reset_dut();
        rstn <= 1'b0;
        repeat (4) @(posedge clk);
        rstn <= 1'b1;
        @(posedge clk);
    endtask

    task automatic write_instr(input int addr, input opcode_t op, input int arg);
        @(posedge clk);
        prog_we   <= 1'b1;
        prog_addr <= addr[5:0];
        prog_data <= {op, arg[7:0]};
        @(posedge clk);
        prog_we   <= 1'b0;
    endtask

    task automatic write_mem(input int addr, input int data);
        @(posedge clk);
        host_req <= '{rd_en: 1'b0, wr_en: 1'b1, addr: addr[7:0], wdata: data[7:0]};
        @(posedge clk);
        host_req <= '0;
    endtask

    task automatic read_range(input int lo, input int hi);
        for (int a = lo; a <= hi; a++) begin
            @(posedge clk);
            host_req <= '{rd_en: 1'b1, wr_en: 1'b0, addr: a[7:0], wdata: 8'h00};
        end
        @(posedge clk);
        host_req <= '0;
        repeat (2) @(posedge clk); // Let the last compare land.
    endtask

    task automatic run_program();
        int n;
        @(posedge clk);
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        n = 0;
        while (!halted && n < 2000) begin
            @(posedge clk);
            n++;
        end
        if (!halted) begin
            $display("Timeout: the core did not halt within %0d cycles.", n);
            timeouts++;
        end
    endtask

    initial begin
        int n;
        int k;
        rstn = 1'b0;
        prog_we = 1'b0;
        prog_addr = '0;
        prog_data = '0;
        host_req = '0;
        start = 1'b0;
        timeouts = 0;
        void'($urandom(87198));

        // Idle state and a plain host write/read.
        reset_dut();
        write_mem(60, 8'h99);
        read_range(60, 60);

        // Constant stores and a memory copy.
        reset_dut();
        write_mem(52, 8'h77);
        write_instr(0, OP_PUSHC, 8'h3c);
        write_instr(1, OP_POPM, 50);
        write_instr(2, OP_PUSHC, 8'ha5);
        write_instr(3, OP_POPM, 51);
        write_instr(4, OP_PUSHM, 52);
        write_instr(5, OP_POPM, 53);
        write_instr(6, OP_HALT, 0);
        run_program();
        read_range(50, 53);

        // Each ALU opcode on the same preloaded pair.
        reset_dut();
        write_mem(0, 200);
        write_mem(1, 100);
        for (int i = 0; i < 4; i++) begin
            write_instr(4*i, OP_PUSHM, 0);
            write_instr(4*i + 1, OP_PUSHM, 1);
            write_instr(4*i + 2, opcode_t'(4 + i), 0);
            write_instr(4*i + 3, OP_POPM, 10 + i);
        end
        write_instr(16, OP_HALT, 0);
        run_program();
        read_range(10, 13);

        // Countdown loop with an iteration counter in mem[3].
        reset_dut();
        write_mem(0, 5);
        write_mem(2, 8'haa);
        write_mem(3, 0);
        write_instr(0, OP_PUSHM, 0);
        write_instr(1, OP_JZ, 10);
        write_instr(2, OP_PUSHC, 1);
        write_instr(3, OP_SUB, 0);
        write_instr(4, OP_PUSHM, 3);
        write_instr(5, OP_PUSHC, 1);
        write_instr(6, OP_ADD, 0);
        write_instr(7, OP_POPM, 3);
        write_instr(8, OP_JMP, 1);
        write_instr(9, OP_HALT, 0);
        write_instr(10, OP_POPM, 2);
        write_instr(11, OP_HALT, 0);
        run_program();
        read_range(0, 3);

        // Overflow, then underflow on a fresh stack.
        reset_dut();
        write_mem(41, 8'h66);
        for (int i = 0; i < 9; i++)
            write_instr(i, OP_PUSHC, i + 1);
        write_instr(9, OP_POPM, 41); // Never reached once the error halts the core.
        write_instr(10, OP_HALT, 0);
        run_program();
        read_range(41, 41);
        reset_dut();
        write_mem(40, 8'h55);
        write_instr(0, OP_POPM, 40);
        write_instr(1, OP_PUSHC, 8'h11);
        write_instr(2, OP_POPM, 40); // Would overwrite mem[40] without the halt.
        write_instr(3, OP_HALT, 0);
        run_program();
        read_range(40, 40);

        // Random straight-line programs.
        for (int t = 0; t < 20; t++) begin
            reset_dut();
            for (int a = 0; a < 32; a++)
                write_mem(a, $urandom);
            n = 4 + $urandom % 9;
            for (int i = 0; i < n; i++) begin
                k = $urandom % 7;
                case (k)
                    0: write_instr(i, OP_PUSHC, $urandom % 256);
                    1: write_instr(i, OP_PUSHM, $urandom % 16);
                    2: write_instr(i, OP_POPM, 16 + $urandom % 16);
                    default: write_instr(i, opcode_t'(k + 1), 0);
                endcase
            end
            write_instr(n, OP_HALT, 0);
            run_program();
            read_range(0, 31);
        end

        $display("Checks finished with %0d errors and %0d timeouts", chk_errors, timeouts);
        if (chk_errors == 0 && timeouts == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: files.f
hw/stk_pkg.sv
hw/push_pop_unit.sv
hw/stack_alu_unit.sv
hw/lifo_stack.sv
hw/data_ram.sv
hw/program_sequencer.sv
hw/stack_cpu_top.sv
verification/stack_cpu_assertions.sv
verification/stack_cpu_checker.sv
verification/stack_cpu_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= stack_cpu_tb
FILELIST  ?= files.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "Simulation completed successfully"

clean:
	rm -rf obj_dir
